/* bench/casper100g_noaxi_tb.sv */
`include "gbe_cfg.svh"

module casper100g_noaxi_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 2000;

    logic                user_clk;
    logic                rst_n;
    logic                gbe_rst;
    gbe_pkg::data_word_t gbe_tx_data;
    logic [3:0]          gbe_tx_valid;
    logic                gbe_tx_end_of_frame;
    gbe_pkg::ip_addr_t   gbe_tx_dest_ip;
    gbe_pkg::udp_port_t  gbe_tx_dest_port;
    logic                gbe_rx_ack;
    logic                gbe_rx_overrun_ack;
    logic                gbe_tx_afull;
    logic                gbe_tx_overflow;
    gbe_pkg::data_word_t gbe_rx_data;
    logic [3:0]          gbe_rx_valid;
    gbe_pkg::ip_addr_t   gbe_rx_source_ip;
    gbe_pkg::udp_port_t  gbe_rx_source_port;
    gbe_pkg::ip_addr_t   gbe_rx_dest_ip;
    gbe_pkg::udp_port_t  gbe_rx_dest_port;
    logic                gbe_rx_end_of_frame;
    logic                gbe_rx_bad_frame;
    logic                gbe_rx_overrun;
    logic                gbe_led_up;
    logic                gbe_led_rx;
    logic                gbe_led_tx;

    // Expected receive words, one entry per queue slot
    gbe_pkg::data_word_t exp_data [$];
    bit                  exp_eof [$];
    gbe_pkg::ip_addr_t   exp_ip [$];
    gbe_pkg::udp_port_t  exp_port [$];

    logic [31:0] lcg_state;
    int          value_errors;
    int          other_errors;
    int          cycle_count;
    int          bad_frame_pulses;
    int          overflow_pulses;
    bit          seen_led_tx;
    bit          seen_led_rx;
    bit          seen_afull;

    casper100g_noaxi dut (
        .user_clk            (user_clk),
        .rst_n               (rst_n),
        .gbe_rst             (gbe_rst),
        .gbe_tx_data         (gbe_tx_data),
        .gbe_tx_valid        (gbe_tx_valid),
        .gbe_tx_end_of_frame (gbe_tx_end_of_frame),
        .gbe_tx_dest_ip      (gbe_tx_dest_ip),
        .gbe_tx_dest_port    (gbe_tx_dest_port),
        .gbe_rx_ack          (gbe_rx_ack),
        .gbe_rx_overrun_ack  (gbe_rx_overrun_ack),
        .gbe_tx_afull        (gbe_tx_afull),
        .gbe_tx_overflow     (gbe_tx_overflow),
        .gbe_rx_data         (gbe_rx_data),
        .gbe_rx_valid        (gbe_rx_valid),
        .gbe_rx_source_ip    (gbe_rx_source_ip),
        .gbe_rx_source_port  (gbe_rx_source_port),
        .gbe_rx_dest_ip      (gbe_rx_dest_ip),
        .gbe_rx_dest_port    (gbe_rx_dest_port),
        .gbe_rx_end_of_frame (gbe_rx_end_of_frame),
        .gbe_rx_bad_frame    (gbe_rx_bad_frame),
        .gbe_rx_overrun      (gbe_rx_overrun),
        .gbe_led_up          (gbe_led_up),
        .gbe_led_rx          (gbe_led_rx),
        .gbe_led_tx          (gbe_led_tx)
    );

    initial begin
        user_clk = 1'b0;
        forever #20 user_clk = ~user_clk;
    end

    always @(posedge user_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a test never finished", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic gbe_pkg::data_word_t random_word();
        gbe_pkg::data_word_t word;
        for (int k = 0; k < 16; k++) begin
            word[k*32 +: 32] = next_random();
        end
        return word;
    endfunction

    task automatic check_word(input string name, input gbe_pkg::data_word_t got,
                              input gbe_pkg::data_word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ip(input string name, input gbe_pkg::ip_addr_t got,
                            input gbe_pkg::ip_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_port(input string name, input gbe_pkg::udp_port_t got,
                              input gbe_pkg::udp_port_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0d ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            value_errors++;
            $display("Error at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // One clock, then sample 2 ns after the edge where outputs have settled
    task automatic step_cycle();
        @(posedge user_clk);
        #2;
        if (gbe_led_tx) seen_led_tx = 1'b1;
        if (gbe_led_rx) seen_led_rx = 1'b1;
        if (gbe_tx_afull) seen_afull = 1'b1;
        if (gbe_rx_bad_frame) bad_frame_pulses++;
        if (gbe_tx_overflow) overflow_pulses++;
    endtask

    // Head word checked against the model before the edge that consumes it
    task automatic compare_head();
        if (exp_data.size() == 0) begin
            other_errors++;
            $display("Receive port presented a word at %0d ns that no test expected", $time);
        end else begin
            check_word("gbe_rx_data", gbe_rx_data, exp_data.pop_front());
            check_flag("gbe_rx_end_of_frame", gbe_rx_end_of_frame, exp_eof.pop_front());
            check_ip("gbe_rx_dest_ip", gbe_rx_dest_ip, exp_ip.pop_front());
            check_port("gbe_rx_dest_port", gbe_rx_dest_port, exp_port.pop_front());
            check_ip("gbe_rx_source_ip", gbe_rx_source_ip, `GBE_LOCAL_IP);
            check_port("gbe_rx_source_port", gbe_rx_source_port, `GBE_LOCAL_PORT);
            check_flag("gbe_rx_valid[3]", gbe_rx_valid[3], 1'b1);
        end
    endtask

    task automatic advance();
        if (gbe_rx_ack && gbe_rx_valid[0]) begin
            compare_head();
        end
        step_cycle();
    endtask

    // Writes one frame; the first keep words go into the receive model
    task automatic send_frame(input gbe_pkg::ip_addr_t ip, input gbe_pkg::udp_port_t port,
                              input int words, input int keep);
        gbe_pkg::data_word_t word;
        for (int i = 0; i < words; i++) begin
            word                = random_word();
            gbe_tx_data         = word;
            gbe_tx_valid        = 4'b0001 << (i % 4);
            gbe_tx_end_of_frame = (i == words - 1);
            gbe_tx_dest_ip      = ip;
            gbe_tx_dest_port    = port;
            if (i < keep) begin
                exp_data.push_back(word);
                exp_eof.push_back(i == words - 1);
                exp_ip.push_back(ip);
                exp_port.push_back(port);
            end
            advance();
        end
        gbe_tx_valid        = '0;
        gbe_tx_end_of_frame = 1'b0;
    endtask

    task automatic drain_expected(input int max_cycles);
        int waited;
        waited     = 0;
        gbe_rx_ack = 1'b1;
        while (exp_data.size() > 0 && waited < max_cycles) begin
            advance();
            waited++;
        end
        if (exp_data.size() > 0) begin
            other_errors++;
            $display("Receive port is missing %0d expected words", exp_data.size());
            exp_data.delete();
            exp_eof.delete();
            exp_ip.delete();
            exp_port.delete();
        end
    endtask

    task automatic wait_link_up();
        int cycles;
        cycles = 0;
        while (!gbe_led_up && cycles < 4 * `GBE_LINK_UP_CYCLES) begin
            advance();
            cycles++;
        end
        check_count("gbe_led_up delay", cycles, `GBE_LINK_UP_CYCLES);
    endtask

    task automatic after_reset();
        check_flag("gbe_rx_valid", |gbe_rx_valid, 1'b0);
        check_flag("gbe_rx_end_of_frame", gbe_rx_end_of_frame, 1'b0);
        check_flag("gbe_rx_bad_frame", gbe_rx_bad_frame, 1'b0);
        check_flag("gbe_rx_overrun", gbe_rx_overrun, 1'b0);
        check_flag("gbe_tx_afull", gbe_tx_afull, 1'b0);
        check_flag("gbe_tx_overflow", gbe_tx_overflow, 1'b0);
        check_flag("gbe_led_up", gbe_led_up, 1'b0);
        check_flag("gbe_led_rx", gbe_led_rx, 1'b0);
        check_flag("gbe_led_tx", gbe_led_tx, 1'b0);
        wait_link_up();
    endtask

    task automatic loopback_frame();
        seen_led_tx = 1'b0;
        seen_led_rx = 1'b0;
        send_frame(`GBE_LOCAL_IP, 16'd5001, 4, 4);
        drain_expected(60);
        check_flag("gbe_led_tx seen", seen_led_tx, 1'b1);
        check_flag("gbe_led_rx seen", seen_led_rx, 1'b1);
    endtask

    task automatic address_filter();
        bad_frame_pulses = 0;
        send_frame(32'h0A00_0099, 16'd6000, 3, 0);
        send_frame(`GBE_LOCAL_IP, 16'd6001, 2, 2);
        drain_expected(80);
        repeat (10) advance();
        check_count("gbe_rx_bad_frame pulses", bad_frame_pulses, 1);
    endtask

    task automatic receive_overrun();
        int waited;
        waited     = 0;
        gbe_rx_ack = 1'b0;
        // Only the words that fit in the receive buffer survive
        send_frame(`GBE_LOCAL_IP, 16'd7000, 12, `GBE_RX_DEPTH);
        while (!gbe_rx_overrun && waited < 100) begin
            advance();
            waited++;
        end
        if (!gbe_rx_overrun) begin
            other_errors++;
            $display("gbe_rx_overrun never rose while the receive buffer was held full");
        end
        repeat (10) advance();
        check_flag("gbe_rx_overrun held", gbe_rx_overrun, 1'b1);
        drain_expected(40);
        repeat (4) advance();
        check_flag("gbe_rx_overrun before ack", gbe_rx_overrun, 1'b1);
        gbe_rx_overrun_ack = 1'b1;
        advance();
        gbe_rx_overrun_ack = 1'b0;
        check_flag("gbe_rx_overrun after ack", gbe_rx_overrun, 1'b0);
    endtask

    task automatic transmit_flags();
        seen_afull      = 1'b0;
        overflow_pulses = 0;
        // Single-word frames stall the framer in IDLE and HEADER, so the buffer fills
        for (int i = 0; i < 20; i++) begin
            send_frame(`GBE_LOCAL_IP, gbe_pkg::udp_port_t'(8000 + i), 1, 1);
        end
        drain_expected(150);
        check_flag("gbe_tx_afull seen", seen_afull, 1'b1);
        check_count("gbe_tx_overflow pulses", overflow_pulses, 0);
        check_flag("gbe_tx_afull drained", gbe_tx_afull, 1'b0);

        seen_afull      = 1'b0;
        overflow_pulses = 0;
        gbe_rst         = 1'b1;
        advance();
        send_frame(`GBE_LOCAL_IP, 16'd8100, 20, 0);
        repeat (2) advance();
        gbe_rst = 1'b0;
        check_count("gbe_tx_overflow pulses in reset", overflow_pulses, 0);
        check_flag("gbe_tx_afull seen in reset", seen_afull, 1'b0);
        check_flag("gbe_tx_afull", gbe_tx_afull, 1'b0);
        check_flag("gbe_rx_valid", |gbe_rx_valid, 1'b0);
        check_flag("gbe_led_up in reset", gbe_led_up, 1'b0);
        wait_link_up();
        repeat (10) advance();
    endtask

    initial begin
        rst_n               = 1'b0;
        gbe_rst             = 1'b0;
        gbe_tx_data         = '0;
        gbe_tx_valid        = '0;
        gbe_tx_end_of_frame = 1'b0;
        gbe_tx_dest_ip      = '0;
        gbe_tx_dest_port    = '0;
        gbe_rx_ack          = 1'b1;
        gbe_rx_overrun_ack  = 1'b0;
        lcg_state           = 32'd34;
        value_errors        = 0;
        other_errors        = 0;
        cycle_count         = 0;
        bad_frame_pulses    = 0;
        overflow_pulses     = 0;
        seen_led_tx         = 1'b0;
        seen_led_rx         = 1'b0;
        seen_afull          = 1'b0;

        repeat (8) step_cycle();
        rst_n = 1'b1;

        after_reset();
        loopback_frame();
        address_filter();
        receive_overrun();
        transmit_flags();

        $display("Checks done: %0d value errors, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+source
source/gbe_pkg.sv
source/gbe_word_fifo.sv
source/udp_tx_framer.sv
source/udp_rx_parser.sv
source/gbe_link_status.sv
source/casper100g_noaxi.sv
bench/casper100g_noaxi_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module casper100g_noaxi_tb -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

/* source/casper100g_noaxi.sv */
`include "gbe_cfg.svh"

module casper100g_noaxi (
    input  logic                user_clk,
    input  logic                rst_n,
    input  logic                gbe_rst,
    // Yellow block transmit side
    input  gbe_pkg::data_word_t gbe_tx_data,
    input  logic [3:0]          gbe_tx_valid,
    input  logic                gbe_tx_end_of_frame,
    input  gbe_pkg::ip_addr_t   gbe_tx_dest_ip,
    input  gbe_pkg::udp_port_t  gbe_tx_dest_port,
    input  logic                gbe_rx_ack,
    input  logic                gbe_rx_overrun_ack,
    output logic                gbe_tx_afull,
    output logic                gbe_tx_overflow,
    // Yellow block receive side
    output gbe_pkg::data_word_t gbe_rx_data,
    output logic [3:0]          gbe_rx_valid,
    output gbe_pkg::ip_addr_t   gbe_rx_source_ip,
    output gbe_pkg::udp_port_t  gbe_rx_source_port,
    output gbe_pkg::ip_addr_t   gbe_rx_dest_ip,
    output gbe_pkg::udp_port_t  gbe_rx_dest_port,
    output logic                gbe_rx_end_of_frame,
    output logic                gbe_rx_bad_frame,
    output logic                gbe_rx_overrun,
    output logic                gbe_led_up,
    output logic                gbe_led_rx,
    output logic                gbe_led_tx
);

    localparam int TX_WIDTH = 561;
    localparam int RX_WIDTH = 609;

    logic [TX_WIDTH-1:0] tx_head;
    logic                tx_empty;
    logic                tx_pop;

    gbe_pkg::data_word_t line_data;
    logic                line_valid;
    logic                line_last;

    logic                rx_wr_en;
    logic [RX_WIDTH-1:0] rx_wr_data;
    logic [RX_WIDTH-1:0] rx_head;
    logic                rx_empty;
    logic                rx_full;
    logic                rx_word_dropped;

    gbe_word_fifo #(
        .WIDTH       (TX_WIDTH),
        .DEPTH       (`GBE_TX_DEPTH),
        .AFULL_LEVEL (`GBE_TX_AFULL_LEVEL)
    ) u_tx_fifo (
        .user_clk (user_clk),
        .rst_n    (rst_n),
        .clear    (gbe_rst),
        // Any valid bit counts as a write
        .wr_en    (|gbe_tx_valid),
        .wr_data  ({gbe_tx_dest_port, gbe_tx_dest_ip, gbe_tx_end_of_frame, gbe_tx_data}),
        .rd_en    (tx_pop),
        .rd_data  (tx_head),
        .empty    (tx_empty),
        .full     (),
        .count    (),
        .afull    (gbe_tx_afull),
        .overflow (gbe_tx_overflow)
    );

    udp_tx_framer u_framer (
        .user_clk      (user_clk),
        .rst_n         (rst_n),
        .clear         (gbe_rst),
        .buf_data      (tx_head[511:0]),
        .buf_eof       (tx_head[512]),
        .buf_dest_ip   (tx_head[544:513]),
        .buf_dest_port (tx_head[560:545]),
        .buf_empty     (tx_empty),
        .buf_pop       (tx_pop),
        .line_data     (line_data),
        .line_valid    (line_valid),
        .line_last     (line_last)
    );

    // Line stream loops straight back in place of MAC and PHY
    udp_rx_parser u_parser (
        .user_clk     (user_clk),
        .rst_n        (rst_n),
        .clear        (gbe_rst),
        .line_data    (line_data),
        .line_valid   (line_valid),
        .line_last    (line_last),
        .rx_buf_full  (rx_full),
        .rx_wr_en     (rx_wr_en),
        .rx_wr_data   (rx_wr_data),
        .bad_frame    (gbe_rx_bad_frame),
        .word_dropped (rx_word_dropped)
    );

    gbe_word_fifo #(
        .WIDTH (RX_WIDTH),
        .DEPTH (`GBE_RX_DEPTH)
    ) u_rx_fifo (
        .user_clk (user_clk),
        .rst_n    (rst_n),
        .clear    (gbe_rst),
        .wr_en    (rx_wr_en),
        .wr_data  (rx_wr_data),
        // Ack only consumes when a word is presented
        .rd_en    (gbe_rx_ack && !rx_empty),
        .rd_data  (rx_head),
        .empty    (rx_empty),
        .full     (rx_full),
        .count    (),
        .afull    (),
        .overflow ()
    );

    assign gbe_rx_valid        = {4{!rx_empty}};
    assign gbe_rx_data         = rx_head[511:0];
    // Buffer memory has no reset, so the flag is held low while nothing is presented
    assign gbe_rx_end_of_frame = rx_head[512] && !rx_empty;
    assign gbe_rx_dest_ip      = rx_head[544:513];
    assign gbe_rx_dest_port    = rx_head[560:545];
    assign gbe_rx_source_ip    = rx_head[592:561];
    assign gbe_rx_source_port  = rx_head[608:593];

    gbe_link_status u_status (
        .user_clk     (user_clk),
        .rst_n        (rst_n),
        .clear        (gbe_rst),
        .rx_activity  (rx_wr_en),
        .tx_activity  (line_valid),
        .word_dropped (rx_word_dropped),
        .overrun_ack  (gbe_rx_overrun_ack),
        .led_up       (gbe_led_up),
        .led_rx       (gbe_led_rx),
        .led_tx       (gbe_led_tx),
        .overrun      (gbe_rx_overrun)
    );

endmodule

/* source/gbe_cfg.svh */
`ifndef GBE_CFG_SVH
`define GBE_CFG_SVH

// Buffer depths in 512-bit words
`define GBE_TX_DEPTH 16
`define GBE_RX_DEPTH 8

// Transmit almost-full threshold, in buffered words
`define GBE_TX_AFULL_LEVEL 12

// Source identity stamped into every outgoing header
`define GBE_LOCAL_IP 32'h0A00_0002
`define GBE_LOCAL_PORT 16'd10000

// Cycles from reset release to link up
`define GBE_LINK_UP_CYCLES 16

// Activity LED hold time in cycles
`define GBE_LED_STRETCH 8

`endif

/* source/gbe_link_status.sv */
`include "gbe_cfg.svh"

module gbe_link_status (
    input  logic user_clk,
    input  logic rst_n,
    input  logic clear,
    input  logic rx_activity,
    input  logic tx_activity,
    input  logic word_dropped,
    input  logic overrun_ack,
    output logic led_up,
    output logic led_rx,
    output logic led_tx,
    output logic overrun
);

    localparam int LINK_W = $clog2(`GBE_LINK_UP_CYCLES + 1);
    localparam int LED_W  = $clog2(`GBE_LED_STRETCH + 1);

    logic [LINK_W-1:0] link_cnt;
    logic [LED_W-1:0]  stretch_cnt [2];
    logic [1:0]        activity;

    // Index 0 is receive, index 1 is transmit
    assign activity = {tx_activity, rx_activity};
    assign led_rx   = (stretch_cnt[0] != '0);
    assign led_tx   = (stretch_cnt[1] != '0);

    always_ff @(posedge user_clk or negedge rst_n) begin
        if (!rst_n) begin
            link_cnt    <= '0;
            led_up      <= 1'b0;
            overrun     <= 1'b0;
            stretch_cnt <= '{default: '0};
        end else if (clear) begin
            link_cnt    <= '0;
            led_up      <= 1'b0;
            overrun     <= 1'b0;
            stretch_cnt <= '{default: '0};
        end else begin
            if (!led_up) begin
                if (link_cnt == LINK_W'(`GBE_LINK_UP_CYCLES - 1)) begin
                    led_up <= 1'b1;
                end else begin
                    link_cnt <= link_cnt + 1'b1;
                end
            end
            // Set wins over acknowledge
            if (word_dropped) begin
                overrun <= 1'b1;
            end else if (overrun_ack) begin
                overrun <= 1'b0;
            end
            for (int i = 0; i < 2; i++) begin
                if (activity[i]) begin
                    stretch_cnt[i] <= LED_W'(`GBE_LED_STRETCH);
                end else if (stretch_cnt[i] != '0) begin
                    stretch_cnt[i] <= stretch_cnt[i] - 1'b1;
                end
            end
        end
    end

endmodule

/* source/gbe_pkg.sv */
package gbe_pkg;

    // One line or payload word
    typedef logic [511:0] data_word_t;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // Wide enough for the deepest buffer
    typedef logic [5:0] fifo_count_t;

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        PAYLOAD
    } framer_state_t;

    typedef enum logic [1:0] {
        EXPECT_HEADER,
        ACCEPT,
        DISCARD
    } parser_state_t;

endpackage

/* source/gbe_word_fifo.sv */
module gbe_word_fifo #(
    parameter int WIDTH       = 561,
    parameter int DEPTH       = 16,
    parameter int AFULL_LEVEL = DEPTH
) (
    input  logic                 user_clk,
    input  logic                 rst_n,
    input  logic                 clear,
    input  logic                 wr_en,
    input  logic [WIDTH-1:0]     wr_data,
    input  logic                 rd_en,
    output logic [WIDTH-1:0]     rd_data,
    output logic                 empty,
    output logic                 full,
    output gbe_pkg::fifo_count_t count,
    output logic                 afull,
    output logic                 overflow
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [AW-1:0]        wr_ptr;
    logic [AW-1:0]        rd_ptr;
    gbe_pkg::fifo_count_t count_next;
    logic                 do_wr;
    logic                 do_rd;

    assign empty = (count == '0);
    assign full  = (count == gbe_pkg::fifo_count_t'(DEPTH));

    // Full drops the write, empty ignores the read
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head word is always visible
    assign rd_data = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (do_wr && !do_rd) begin
            count_next = count + 1'b1;
        end else if (do_rd && !do_wr) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge user_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge user_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            afull    <= 1'b0;
            overflow <= 1'b0;
        end else if (clear) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            afull    <= 1'b0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count    <= count_next;
            // Level tracks the occupancy that the count takes this edge
            afull    <= (count_next >= gbe_pkg::fifo_count_t'(AFULL_LEVEL));
            overflow <= wr_en && full;
        end
    end

    a_no_read_empty: assert property (
        @(posedge user_clk) disable iff (!rst_n) !(rd_en && empty)
    );

    a_count_bound: assert property (
        @(posedge user_clk) disable iff (!rst_n)
        count <= gbe_pkg::fifo_count_t'(DEPTH)
    );

endmodule

/* source/udp_rx_parser.sv */
`include "gbe_cfg.svh"

module udp_rx_parser (
    input  logic                user_clk,
    input  logic                rst_n,
    input  logic                clear,
    input  gbe_pkg::data_word_t line_data,
    input  logic                line_valid,
    input  logic                line_last,
    input  logic                rx_buf_full,
    output logic                rx_wr_en,
    output logic [608:0]        rx_wr_data,
    output logic                bad_frame,
    output logic                word_dropped
);

    gbe_pkg::parser_state_t state;

    // Fields of the current frame header
    gbe_pkg::ip_addr_t   hdr_dest_ip;
    gbe_pkg::udp_port_t  hdr_dest_port;
    gbe_pkg::ip_addr_t   hdr_src_ip;
    gbe_pkg::udp_port_t  hdr_src_port;

    // Payload word waiting one cycle for the buffer write
    logic                pend_valid;
    logic                pend_eof;
    gbe_pkg::data_word_t pend_data;

    // Full is sampled in the write cycle, so a word is never pushed into a full buffer
    assign rx_wr_en     = pend_valid && !rx_buf_full;
    assign word_dropped = pend_valid && rx_buf_full;
    assign rx_wr_data   = {hdr_src_port, hdr_src_ip, hdr_dest_port, hdr_dest_ip,
                           pend_eof, pend_data};

    always_ff @(posedge user_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= gbe_pkg::EXPECT_HEADER;
            pend_valid <= 1'b0;
            bad_frame  <= 1'b0;
        end else if (clear) begin
            state      <= gbe_pkg::EXPECT_HEADER;
            pend_valid <= 1'b0;
            bad_frame  <= 1'b0;
        end else begin
            pend_valid <= 1'b0;
            bad_frame  <= 1'b0;
            case (state)
                gbe_pkg::EXPECT_HEADER: begin
                    if (line_valid) begin
                        // Destination filter
                        if (line_data[31:0] == `GBE_LOCAL_IP) begin
                            state <= gbe_pkg::ACCEPT;
                        end else begin
                            state <= gbe_pkg::DISCARD;
                        end
                    end
                end
                gbe_pkg::ACCEPT: begin
                    if (line_valid) begin
                        pend_valid <= 1'b1;
                        if (line_last) begin
                            state <= gbe_pkg::EXPECT_HEADER;
                        end
                    end
                end
                gbe_pkg::DISCARD: begin
                    if (line_valid && line_last) begin
                        bad_frame <= 1'b1;
                        state     <= gbe_pkg::EXPECT_HEADER;
                    end
                end
                default: state <= gbe_pkg::EXPECT_HEADER;
            endcase
        end
    end

    always_ff @(posedge user_clk) begin
        if (state == gbe_pkg::EXPECT_HEADER && line_valid) begin
            hdr_dest_ip   <= line_data[31:0];
            hdr_dest_port <= line_data[47:32];
            hdr_src_ip    <= line_data[79:48];
            hdr_src_port  <= line_data[95:80];
        end
        if (line_valid) begin
            pend_data <= line_data;
            pend_eof  <= line_last;
        end
    end

    // Only frames addressed to this node reach the receive buffer
    a_write_local_frame: assert property (
        @(posedge user_clk) disable iff (!rst_n)
        rx_wr_en |-> (hdr_dest_ip == `GBE_LOCAL_IP)
    );

endmodule

/* source/udp_tx_framer.sv */
`include "gbe_cfg.svh"

module udp_tx_framer (
    input  logic               user_clk,
    input  logic               rst_n,
    input  logic               clear,
    input  gbe_pkg::data_word_t buf_data,
    input  logic               buf_eof,
    input  gbe_pkg::ip_addr_t  buf_dest_ip,
    input  gbe_pkg::udp_port_t buf_dest_port,
    input  logic               buf_empty,
    output logic               buf_pop,
    output gbe_pkg::data_word_t line_data,
    output logic               line_valid,
    output logic               line_last
);

    gbe_pkg::framer_state_t state;
    gbe_pkg::data_word_t    header_word;

    // Header fields come from the first buffered word of the frame
    always_comb begin
        header_word        = '0;
        header_word[31:0]  = buf_dest_ip;
        header_word[47:32] = buf_dest_port;
        header_word[79:48] = `GBE_LOCAL_IP;
        header_word[95:80] = `GBE_LOCAL_PORT;
    end

    assign buf_pop = (state == gbe_pkg::PAYLOAD) && !buf_empty;

    always_ff @(posedge user_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= gbe_pkg::IDLE;
            line_valid <= 1'b0;
            line_last  <= 1'b0;
        end else if (clear) begin
            state      <= gbe_pkg::IDLE;
            line_valid <= 1'b0;
            line_last  <= 1'b0;
        end else begin
            line_valid <= 1'b0;
            line_last  <= 1'b0;
            case (state)
                gbe_pkg::IDLE: begin
                    if (!buf_empty) begin
                        state <= gbe_pkg::HEADER;
                    end
                end
                gbe_pkg::HEADER: begin
                    line_valid <= 1'b1;
                    state      <= gbe_pkg::PAYLOAD;
                end
                gbe_pkg::PAYLOAD: begin
                    // Buffer running dry leaves a gap inside the frame
                    if (!buf_empty) begin
                        line_valid <= 1'b1;
                        line_last  <= buf_eof;
                        if (buf_eof) begin
                            state <= gbe_pkg::IDLE;
                        end
                    end
                end
                default: state <= gbe_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge user_clk) begin
        if (state == gbe_pkg::HEADER) begin
            line_data <= header_word;
        end else if (buf_pop) begin
            line_data <= buf_data;
        end
    end

    // Idle cycle after every frame end, so a new header never meets a pending write
    a_gap_after_last: assert property (
        @(posedge user_clk) disable iff (!rst_n) line_last |=> !line_valid
    );

endmodule
